// File: src/dm_defines.svh
`ifndef DM_DEFINES_SVH
`define DM_DEFINES_SVH

// ============================================================
// Data memory stage sizing
// ============================================================

// Word size of the datapath and of every RAM entry.
`define DM_DATA_WIDTH 32

// Byte address bits decoded by the RAM.
// Bits 1:0 pick the byte lane; the rest index the word array.
`define DM_ADDR_WIDTH 15

// Array depth in words, from the decoded address bits.
`define DM_WORDS (1 << (`DM_ADDR_WIDTH - 2))

// ============================================================
// Legal byte-address window, both ends inclusive
// ============================================================

// Lowest legal byte address.
`define DM_ADDR_LB 32'h0000_0000

// Highest legal byte address.
// It matches the top of the RAM, so no access wraps.
`define DM_ADDR_UB 32'h0000_7FFF

`endif

// File: src/dm_pkg.sv
`default_nettype none

package dm_pkg;

	// ============================================================
	// Access modes
	// ============================================================

	// One mode per request; it applies to loads and stores alike.
	typedef enum logic [2:0] {
		DM_NONE = 3'd0, // No access this cycle.
		DM_W    = 3'd1, // Full word.
		DM_H    = 3'd2, // Half, sign-extended on load.
		DM_HU   = 3'd3, // Half, zero-extended on load.
		DM_B    = 3'd4, // Byte, sign-extended on load.
		DM_BU   = 3'd5  // Byte, zero-extended on load.
	} dm_mode_e;

	// ============================================================
	// Controller state
	// ============================================================

	// DM_LOAD marks the cycle in which the RAM returns a load.
	typedef enum logic {
		DM_IDLE = 1'b0, // No read in flight.
		DM_LOAD = 1'b1  // Read data arrives this cycle.
	} dm_state_e;

endpackage

`default_nettype wire

// File: src/dm_addr_check.sv
`default_nettype none

`include "dm_defines.svh"

module dm_addr_check (
	input  wire logic [`DM_DATA_WIDTH-1:0] read_addr,
	input  wire logic [`DM_DATA_WIDTH-1:0] write_addr,
	input  wire logic                      write_enable,
	input  wire dm_pkg::dm_mode_e          mode,
	output logic [`DM_DATA_WIDTH-1:0]      op_addr,
	output logic                           access_ok
);

	import dm_pkg::*;

	logic in_window; // Address inside the legal range.
	logic aligned;   // Address meets the mode's alignment.

	// Stores use the write address, everything else the read address.
	assign op_addr = write_enable ? write_addr : read_addr;

	// Offset from the low bound, compared against the window span.
	// One unsigned compare covers both ends.
	assign in_window = (op_addr - `DM_ADDR_LB) <= (`DM_ADDR_UB - `DM_ADDR_LB);

	// ============================================================
	// Alignment by access size
	// ============================================================

	always_comb begin
		case (mode)
			DM_W:        aligned = (op_addr[1:0] == 2'b00); // Word boundary.
			DM_H, DM_HU: aligned = !op_addr[0];             // Half boundary.
			DM_B, DM_BU: aligned = 1'b1;                    // Any byte.
			default:     aligned = 1'b0;                    // Unused codes.
		endcase
	end

	// No access is always fine; any other mode needs both rules.
	assign access_ok = (mode == DM_NONE) || (in_window && aligned);

endmodule

`default_nettype wire

// File: src/dm_ctrl.sv
`default_nettype none

module dm_ctrl (
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             write_enable,
	input  wire logic             stop,
	input  wire logic             access_ok,
	input  wire dm_pkg::dm_mode_e mode,
	input  wire logic [1:0]       addr_low,
	output logic                  store_go,
	output logic                  load_go,
	output dm_pkg::dm_mode_e      load_mode,
	output logic [1:0]            load_offset,
	output logic                  read_done
);

	import dm_pkg::*;

	dm_state_e state;      // Current state.
	dm_state_e state_next; // State after this edge.
	logic      req_live;   // Request that may touch the RAM.

	// ============================================================
	// Request decode
	// ============================================================

	// Legal, not stopped, and actually asking for something.
	assign req_live = access_ok && !stop && (mode != DM_NONE);

	assign store_go = req_live && write_enable;  // Write at this edge.
	assign load_go  = req_live && !write_enable; // Read issued at this edge.

	// ============================================================
	// State and load context
	// ============================================================

	// A new load always refills the slot, so loads pipeline one per cycle.
	assign state_next = load_go ? DM_LOAD : DM_IDLE;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DM_IDLE; // Nothing in flight.
		end else begin
			state <= state_next;
		end
	end

	// Mode and lane of the read now in the RAM pipeline.
	always_ff @(posedge clk) begin
		if (load_go) begin
			load_mode   <= mode;     // Extension rule for the return.
			load_offset <= addr_low; // Byte offset inside the word.
		end
	end

	// High for exactly the cycle the RAM word is on rdata.
	assign read_done = (state == DM_LOAD);

	// ============================================================
	// Checks
	// ============================================================

	// Undefined mode codes must be refused by the address check.
	issue_known_mode_a : assert property (@(posedge clk) disable iff (rst)
		(store_go || load_go) |-> (mode inside {DM_W, DM_H, DM_HU, DM_B, DM_BU}));

	// A strobed access already meets the alignment of its mode.
	issue_aligned_a : assert property (@(posedge clk) disable iff (rst)
		(store_go || load_go) |->
			(((mode != DM_W) || (addr_low == 2'b00)) &&
			(!(mode inside {DM_H, DM_HU}) || !addr_low[0])));

endmodule

`default_nettype wire

// File: src/dm_store_align.sv
`default_nettype none

`include "dm_defines.svh"

module dm_store_align (
	input  wire logic                      store_go,
	input  wire dm_pkg::dm_mode_e          mode,
	input  wire logic [1:0]                addr_low,
	input  wire logic [`DM_DATA_WIDTH-1:0] write_data,
	output logic [`DM_DATA_WIDTH/8-1:0]    byte_we,
	output logic [`DM_DATA_WIDTH-1:0]      lane_data
);

	import dm_pkg::*;

	localparam int HALF_W = `DM_DATA_WIDTH / 2; // Half width in bits.
	localparam int LANES  = `DM_DATA_WIDTH / 8; // Byte lanes per word.

	// ============================================================
	// Lane data
	// ============================================================

	// The low half or byte is copied to every lane it could land on.
	// The enables then pick the lane that is really written.
	always_comb begin
		case (mode)
			DM_H, DM_HU: lane_data = {2{write_data[HALF_W-1:0]}}; // Both halves.
			DM_B, DM_BU: lane_data = {LANES{write_data[7:0]}};    // All bytes.
			default:     lane_data = write_data;                  // Word as is.
		endcase
	end

	// ============================================================
	// Byte enables
	// ============================================================

	always_comb begin
		byte_we = '0; // Nothing written by default.
		if (store_go) begin
			case (mode)
				DM_W:        byte_we = '1;                               // Whole word.
				DM_H, DM_HU: byte_we = addr_low[1] ? 4'b1100 : 4'b0011;  // Upper or lower.
				DM_B, DM_BU: byte_we = 4'b0001 << addr_low;              // One lane.
				default:     byte_we = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/dm_ram.sv
`default_nettype none

`include "dm_defines.svh"

module dm_ram (
	input  wire logic                       clk,
	input  wire logic [`DM_DATA_WIDTH/8-1:0] byte_we,
	input  wire logic [`DM_ADDR_WIDTH-3:0]   word_addr,
	input  wire logic [`DM_DATA_WIDTH-1:0]   wdata,
	output logic [`DM_DATA_WIDTH-1:0]        rdata
);

	localparam int LANES = `DM_DATA_WIDTH / 8; // Byte lanes per word.

	// Word array, one byte enable per lane.
	logic [`DM_DATA_WIDTH-1:0] mem [`DM_WORDS];

	// ============================================================
	// Write and registered read
	// ============================================================

	// Read before write, so the same address returns old data.
	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES; i++) begin
			if (byte_we[i]) begin
				mem[word_addr][8*i +: 8] <= wdata[8*i +: 8]; // Enabled lane only.
			end
		end
		rdata <= mem[word_addr]; // Available next cycle.
	end

endmodule

`default_nettype wire

// File: src/dm_load_align.sv
`default_nettype none

`include "dm_defines.svh"

module dm_load_align (
	input  wire logic                      read_done,
	input  wire dm_pkg::dm_mode_e          load_mode,
	input  wire logic [1:0]                load_offset,
	input  wire logic [`DM_DATA_WIDTH-1:0] rdata,
	output logic [`DM_DATA_WIDTH-1:0]      read_result
);

	import dm_pkg::*;

	localparam int HALF_W = `DM_DATA_WIDTH / 2; // Half width in bits.

	logic [HALF_W-1:0] half_sel; // Addressed half.
	logic [7:0]        byte_sel; // Addressed byte.

	// ============================================================
	// Lane select
	// ============================================================

	// Offset bit 1 picks the half.
	assign half_sel = load_offset[1] ? rdata[`DM_DATA_WIDTH-1:HALF_W] : rdata[HALF_W-1:0];

	// Both offset bits pick the byte.
	assign byte_sel = rdata[8*load_offset +: 8];

	// ============================================================
	// Extension
	// ============================================================

	always_comb begin
		case (load_mode)
			DM_W:    read_result = rdata;                                            // As stored.
			DM_H:    read_result = {{(`DM_DATA_WIDTH-HALF_W){half_sel[HALF_W-1]}}, half_sel};
			DM_HU:   read_result = {{(`DM_DATA_WIDTH-HALF_W){1'b0}}, half_sel};      // Zero fill.
			DM_B:    read_result = {{(`DM_DATA_WIDTH-8){byte_sel[7]}}, byte_sel};    // Sign fill.
			DM_BU:   read_result = {{(`DM_DATA_WIDTH-8){1'b0}}, byte_sel};           // Zero fill.
			default: read_result = '0;
		endcase
		// Quiet bus outside the return cycle.
		if (!read_done) begin
			read_result = '0;
		end
	end

endmodule

`default_nettype wire

// File: src/dm_top.sv
`default_nettype none

`include "dm_defines.svh"

module dm_top (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic [`DM_DATA_WIDTH-1:0] read_addr,
	input  wire logic [`DM_DATA_WIDTH-1:0] write_addr,
	input  wire logic [`DM_DATA_WIDTH-1:0] write_data,
	input  wire logic                      write_enable,
	input  wire dm_pkg::dm_mode_e          mode,
	input  wire logic                      stop,
	output logic [`DM_DATA_WIDTH-1:0]      read_result,
	output logic                           valid,
	output logic                           read_done
);

	import dm_pkg::*;

	logic [`DM_DATA_WIDTH-1:0]   op_addr;     // Address of this request.
	logic                        access_ok;   // Window and alignment pass.
	logic                        store_go;    // Write strobe.
	logic                        load_go;     // Read issue strobe.
	dm_mode_e                    load_mode;   // Mode of the returning read.
	logic [1:0]                  load_offset; // Lane of the returning read.
	logic [`DM_DATA_WIDTH/8-1:0] byte_we;     // Per-lane write enables.
	logic [`DM_DATA_WIDTH-1:0]   lane_data;   // Store data on its lanes.
	logic [`DM_DATA_WIDTH-1:0]   rdata;       // Raw RAM word.

	// Legality is reported the same cycle.
	assign valid = access_ok;

	// ============================================================
	// Request side
	// ============================================================

	dm_addr_check dm_addr_check_i (
		.read_addr    (read_addr),
		.write_addr   (write_addr),
		.write_enable (write_enable),
		.mode         (mode),
		.op_addr      (op_addr),
		.access_ok    (access_ok)
	);

	dm_ctrl dm_ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.write_enable (write_enable),
		.stop         (stop),
		.access_ok    (access_ok),
		.mode         (mode),
		.addr_low     (op_addr[1:0]),
		.store_go     (store_go),
		.load_go      (load_go),
		.load_mode    (load_mode),
		.load_offset  (load_offset),
		.read_done    (read_done)
	);

	// ============================================================
	// Datapath
	// ============================================================

	dm_store_align dm_store_align_i (
		.store_go   (store_go),
		.mode       (mode),
		.addr_low   (op_addr[1:0]),
		.write_data (write_data),
		.byte_we    (byte_we),
		.lane_data  (lane_data)
	);

	// Word index drops the two byte-lane bits.
	dm_ram dm_ram_i (
		.clk       (clk),
		.byte_we   (byte_we),
		.word_addr (op_addr[`DM_ADDR_WIDTH-1:2]),
		.wdata     (lane_data),
		.rdata     (rdata)
	);

	dm_load_align dm_load_align_i (
		.read_done   (read_done),
		.load_mode   (load_mode),
		.load_offset (load_offset),
		.rdata       (rdata),
		.read_result (read_result)
	);

endmodule

`default_nettype wire

// File: tests/tb_dm_top.sv
`default_nettype none

`include "dm_defines.svh"

module tb_dm_top;

	timeunit 1ns;
	timeprecision 1ps;

	import dm_pkg::*;

	localparam int MAX_ENTRIES = 96;  // Table capacity.
	localparam int SPAN        = 1 << `DM_ADDR_WIDTH; // Bytes in the model.

	logic                      clk = 1'b0;
	logic                      rst;
	logic [`DM_DATA_WIDTH-1:0] read_addr;
	logic [`DM_DATA_WIDTH-1:0] write_addr;
	logic [`DM_DATA_WIDTH-1:0] write_data;
	logic                      write_enable;
	dm_mode_e                  mode;
	logic                      stop;
	logic [`DM_DATA_WIDTH-1:0] read_result;
	logic                      valid;
	logic                      read_done;

	// Stimulus table, one request per entry.
	logic                      tab_we     [MAX_ENTRIES];
	dm_mode_e                  tab_mode   [MAX_ENTRIES];
	logic [`DM_DATA_WIDTH-1:0] tab_addr   [MAX_ENTRIES];
	logic [`DM_DATA_WIDTH-1:0] tab_data   [MAX_ENTRIES];
	logic                      tab_stop   [MAX_ENTRIES];
	logic                      tab_valid  [MAX_ENTRIES];
	logic                      tab_done   [MAX_ENTRIES];
	logic [`DM_DATA_WIDTH-1:0] tab_result [MAX_ENTRIES];

	logic [7:0]  ref_mem [SPAN]; // Byte-wide reference memory.
	logic [31:0] lcg_state = 32'd19072; // Generator seed.
	int          n_entries = 0;
	int          errors    = 0;
	logic        table_ready = 1'b0;

	dm_top dm_top_i (
		.clk          (clk),
		.rst          (rst),
		.read_addr    (read_addr),
		.write_addr   (write_addr),
		.write_data   (write_data),
		.write_enable (write_enable),
		.mode         (mode),
		.stop         (stop),
		.read_result  (read_result),
		.valid        (valid),
		.read_done    (read_done)
	);

	always #5 clk = ~clk; // 10 ns period.

	// ============================================================
	// Reference model
	// ============================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223; // Numerical Recipes constants.
		return lcg_state;
	endfunction

	function automatic int access_bytes(dm_mode_e m);
		case (m)
			DM_W:        return 4;
			DM_H, DM_HU: return 2;
			DM_B, DM_BU: return 1;
			default:     return 0;
		endcase
	endfunction

	function automatic logic model_legal(dm_mode_e m, logic [31:0] a);
		logic aligned;
		case (m)
			DM_W:        aligned = (a % 4 == 0); // Word boundary.
			DM_H, DM_HU: aligned = (a % 2 == 0); // Half boundary.
			default:     aligned = 1'b1;
		endcase
		if (m == DM_NONE) begin
			return 1'b1; // No access, nothing to refuse.
		end
		return aligned && (a >= `DM_ADDR_LB) && (a <= `DM_ADDR_UB);
	endfunction

	// Little-endian, byte k of the data lands at address a + k.
	task automatic model_write(dm_mode_e m, logic [31:0] a, logic [31:0] d);
		logic [`DM_ADDR_WIDTH-1:0] idx;
		for (int k = 0; k < access_bytes(m); k++) begin
			idx = a[`DM_ADDR_WIDTH-1:0] + `DM_ADDR_WIDTH'(k);
			ref_mem[idx] = 8'(d >> (8 * k));
		end
	endtask

	function automatic logic [31:0] model_read(dm_mode_e m, logic [31:0] a);
		logic [31:0]               raw;
		logic [`DM_ADDR_WIDTH-1:0] idx;
		raw = '0;
		for (int k = 0; k < access_bytes(m); k++) begin
			idx = a[`DM_ADDR_WIDTH-1:0] + `DM_ADDR_WIDTH'(k);
			raw = raw | (32'(ref_mem[idx]) << (8 * k)); // Gather bytes upward.
		end
		case (m)
			DM_H:    return {{16{raw[15]}}, raw[15:0]}; // Sign fill.
			DM_B:    return {{24{raw[7]}}, raw[7:0]};
			default: return raw; // Unsigned modes already zero-filled.
		endcase
	endfunction

	// ============================================================
	// Table construction
	// ============================================================

	task automatic add_entry(logic we, dm_mode_e m, logic [31:0] a, logic [31:0] d,
		logic st, logic exp_valid, logic [31:0] exp_result);
		tab_we[n_entries]     = we;
		tab_mode[n_entries]   = m;
		tab_addr[n_entries]   = a;
		tab_data[n_entries]   = d;
		tab_stop[n_entries]   = st;
		tab_valid[n_entries]  = exp_valid;
		tab_done[n_entries]   = exp_valid && !st && !we && (m != DM_NONE); // A live load.
		tab_result[n_entries] = exp_result;
		if (we && !st && (m != DM_NONE) && model_legal(m, a)) begin
			model_write(m, a, d); // Keep the model in step.
		end
		n_entries++;
	endtask

	// Expected values come from the model.
	task automatic add_model_entry(logic we, dm_mode_e m, logic [31:0] a, logic [31:0] d,
		logic st);
		logic        ok;
		logic [31:0] res;
		ok  = model_legal(m, a);
		res = (!we && ok) ? model_read(m, a) : 32'h0;
		add_entry(we, m, a, d, st, ok, res);
	endtask

	function automatic dm_mode_e random_load_mode(int k);
		case (k % 8)
			0, 5:    return DM_W;
			1:       return DM_H;
			2, 6:    return DM_HU;
			4:       return DM_BU;
			default: return DM_B;
		endcase
	endfunction

	task automatic build_table();
		dm_mode_e m;
		int       off;
		// Word round trip.
		add_entry(1'b1, DM_W,  32'h0000_0100, 32'h1234_5678, 1'b0, 1'b1, 32'h0);
		add_entry(1'b0, DM_W,  32'h0000_0100, 32'h0,         1'b0, 1'b1, 32'h1234_5678);
		// Partial stores merge into one word.
		add_entry(1'b1, DM_W,  32'h0000_0200, 32'hAABB_CCDD, 1'b0, 1'b1, 32'h0);
		add_entry(1'b1, DM_H,  32'h0000_0202, 32'h0000_1122, 1'b0, 1'b1, 32'h0);
		add_entry(1'b1, DM_B,  32'h0000_0200, 32'h0000_0033, 1'b0, 1'b1, 32'h0);
		add_entry(1'b1, DM_BU, 32'h0000_0201, 32'hFFFF_FF44, 1'b0, 1'b1, 32'h0);
		add_entry(1'b0, DM_W,  32'h0000_0200, 32'h0,         1'b0, 1'b1, 32'h1122_4433);
		add_entry(1'b0, DM_HU, 32'h0000_0202, 32'h0,         1'b0, 1'b1, 32'h0000_1122);
		// Extension at every offset, loads back to back.
		add_entry(1'b1, DM_W,  32'h0000_0300, 32'h80FF_7F01, 1'b0, 1'b1, 32'h0);
		add_entry(1'b0, DM_B,  32'h0000_0300, 32'h0,         1'b0, 1'b1, 32'h0000_0001);
		add_entry(1'b0, DM_BU, 32'h0000_0300, 32'h0,         1'b0, 1'b1, 32'h0000_0001);
		add_entry(1'b0, DM_B,  32'h0000_0301, 32'h0,         1'b0, 1'b1, 32'h0000_007F);
		add_entry(1'b0, DM_BU, 32'h0000_0301, 32'h0,         1'b0, 1'b1, 32'h0000_007F);
		add_entry(1'b0, DM_B,  32'h0000_0302, 32'h0,         1'b0, 1'b1, 32'hFFFF_FFFF);
		add_entry(1'b0, DM_BU, 32'h0000_0302, 32'h0,         1'b0, 1'b1, 32'h0000_00FF);
		add_entry(1'b0, DM_B,  32'h0000_0303, 32'h0,         1'b0, 1'b1, 32'hFFFF_FF80);
		add_entry(1'b0, DM_BU, 32'h0000_0303, 32'h0,         1'b0, 1'b1, 32'h0000_0080);
		add_entry(1'b0, DM_H,  32'h0000_0300, 32'h0,         1'b0, 1'b1, 32'h0000_7F01);
		add_entry(1'b0, DM_HU, 32'h0000_0300, 32'h0,         1'b0, 1'b1, 32'h0000_7F01);
		add_entry(1'b0, DM_H,  32'h0000_0302, 32'h0,         1'b0, 1'b1, 32'hFFFF_80FF);
		add_entry(1'b0, DM_HU, 32'h0000_0302, 32'h0,         1'b0, 1'b1, 32'h0000_80FF);
		add_entry(1'b0, DM_W,  32'h0000_0300, 32'h0,         1'b0, 1'b1, 32'h80FF_7F01);
		// Refused accesses touch nothing.
		add_entry(1'b1, DM_W,  32'h0000_0000, 32'hCAFE_0001, 1'b0, 1'b1, 32'h0);
		add_entry(1'b1, DM_W,  32'h0000_0400, 32'h5566_7788, 1'b0, 1'b1, 32'h0);
		add_entry(1'b1, DM_W,  32'h0000_0401, 32'hDEAD_BEEF, 1'b0, 1'b0, 32'h0);
		add_entry(1'b1, DM_H,  32'h0000_0403, 32'hDEAD_BEEF, 1'b0, 1'b0, 32'h0);
		add_entry(1'b1, DM_W,  32'h0000_8000, 32'hDEAD_BEEF, 1'b0, 1'b0, 32'h0); // Aliases word 0.
		add_entry(1'b1, DM_B,  32'h0001_0000, 32'hDEAD_BEEF, 1'b0, 1'b0, 32'h0);
		add_entry(1'b0, DM_W,  32'h0000_0402, 32'h0,         1'b0, 1'b0, 32'h0);
		add_entry(1'b0, DM_H,  32'h0000_0401, 32'h0,         1'b0, 1'b0, 32'h0);
		add_entry(1'b0, DM_BU, 32'h0000_8000, 32'h0,         1'b0, 1'b0, 32'h0);
		add_entry(1'b0, DM_W,  32'h0000_0400, 32'h0,         1'b0, 1'b1, 32'h5566_7788);
		add_entry(1'b0, DM_W,  32'h0000_0000, 32'h0,         1'b0, 1'b1, 32'hCAFE_0001);
		add_entry(1'b1, DM_B,  32'h0000_7FFF, 32'h0000_00A5, 1'b0, 1'b1, 32'h0); // Window top.
		add_entry(1'b0, DM_BU, 32'h0000_7FFF, 32'h0,         1'b0, 1'b1, 32'h0000_00A5);
		add_entry(1'b0, DM_B,  32'h0000_7FFF, 32'h0,         1'b0, 1'b1, 32'hFFFF_FFA5);
		add_entry(1'b0, DM_NONE, 32'hFFFF_FFFF, 32'h0,       1'b0, 1'b1, 32'h0);
		add_entry(1'b1, DM_NONE, 32'h0000_0400, 32'h0,       1'b0, 1'b1, 32'h0);
		add_entry(1'b0, DM_W,  32'h0000_0400, 32'h0,         1'b0, 1'b1, 32'h5566_7788);
		// Stop holds off stores and loads.
		add_entry(1'b1, DM_W,  32'h0000_0500, 32'h0102_0304, 1'b0, 1'b1, 32'h0);
		add_entry(1'b1, DM_W,  32'h0000_0500, 32'hFFFF_FFFF, 1'b1, 1'b1, 32'h0);
		add_entry(1'b0, DM_W,  32'h0000_0500, 32'h0,         1'b1, 1'b1, 32'h0);
		add_entry(1'b0, DM_W,  32'h0000_0500, 32'h0,         1'b0, 1'b1, 32'h0102_0304);
		// Random words, random bytes over them, then mixed loads.
		for (int k = 0; k < 8; k++) begin
			add_model_entry(1'b1, DM_W, 32'h600 + 32'(4 * k), lcg_next(), 1'b0);
		end
		for (int k = 0; k < 8; k++) begin
			add_model_entry(1'b1, DM_B, 32'h600 + 32'(4 * k + k % 4), lcg_next(), 1'b0);
		end
		for (int k = 0; k < 8; k++) begin
			m = random_load_mode(k);
			case (m)
				DM_W:        off = 0;
				DM_H, DM_HU: off = 2 * (k % 2);
				default:     off = k % 4;
			endcase
			add_model_entry(1'b0, m, 32'h600 + 32'(4 * k + off), 32'h0, 1'b0);
		end
	endtask

	// ============================================================
	// Drive and check
	// ============================================================

	task automatic drive_entry(int i);
		write_enable <= tab_we[i];
		mode         <= tab_mode[i];
		write_data   <= tab_data[i];
		stop         <= tab_stop[i];
		// The unused address points somewhere illegal.
		write_addr   <= tab_we[i] ? tab_addr[i] : 32'hFFFF_FFF1;
		read_addr    <= tab_we[i] ? 32'hFFFF_FFF1 : tab_addr[i];
	endtask

	task automatic check_return(int i, logic exp_done, logic [31:0] exp_res);
		logic [31:0] want;
		want = exp_done ? exp_res : 32'h0; // Quiet bus outside a return.
		assert (read_done === exp_done) else begin
			errors++;
			$display("ERROR: read_done after entry %0d got %h expected %h",
				i, read_done, exp_done);
		end
		assert (read_result === want) else begin
			errors++;
			$display("ERROR: read_result after entry %0d got %h expected %h",
				i, read_result, want);
		end
	endtask

	initial begin
		rst          <= 1'b1;
		read_addr    <= '0;
		write_addr   <= '0;
		write_data   <= '0;
		write_enable <= 1'b0;
		mode         <= DM_NONE;
		stop         <= 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i <= n_entries; i++) begin
			@(posedge clk);
			if (i < n_entries) begin
				drive_entry(i);
			end else begin
				write_enable <= 1'b0; // Idle cycle collects the last return.
				mode         <= DM_NONE;
			end
			@(negedge clk);
			if (i < n_entries) begin
				assert (valid === tab_valid[i]) else begin
					errors++;
					$display("ERROR: valid at entry %0d got %h expected %h",
						i, valid, tab_valid[i]);
				end
			end
			if (i == 0) begin
				check_return(i, 1'b0, 32'h0); // Nothing in flight after reset.
			end else begin
				check_return(i - 1, tab_done[i-1], tab_result[i-1]);
			end
		end
		$display("Checked %0d entries, %0d errors", n_entries, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the table.
	initial begin
		wait (table_ready);
		#((n_entries + 50) * 10);
		$display("Watchdog expired before all entries were applied");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/dm_pkg.sv
src/dm_addr_check.sv
src/dm_ctrl.sv
src/dm_store_align.sv
src/dm_ram.sv
src/dm_load_align.sv
src/dm_top.sv
tests/tb_dm_top.sv

// File: Makefile
# Verilator build for the data memory stage

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_dm_top
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

SIM_EXE   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The log decides pass or fail.
run: compile
	./$(SIM_EXE) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
